// ==== verilog/mgmt_macros.svh ====
`ifndef MGMT_MACROS_SVH
`define MGMT_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Bus geometry

`define MGMT_ADDR_BITS		16
`define MGMT_DATA_BITS		8

// Crossbar and front panel sizes
`define MUX_CHANNELS		12
`define MUXSEL_BITS			4
`define TRIG_CHANNELS		12
// Relays sit on the top outputs, 8 to 11
`define RELAY_CHANNELS		4

////////////////////////////////////////////////////////////////////////////
// Register map

// Identity, MSB first
`define REG_FPGA_IDCODE		16'h0000
`define REG_FPGA_SERIAL		16'h0004

// Sensors, LSB first, two bytes each
`define REG_FAN0_RPM		16'h0010
`define REG_FAN1_RPM		16'h0012
`define REG_DIE_TEMP		16'h0014
`define REG_VOLT_CORE		16'h0016
`define REG_VOLT_RAM		16'h0018
`define REG_VOLT_AUX		16'h001a

// Front panel serial port, LED bytes at 0x53..0x55
`define REG_FRONT_CTRL		16'h0050
`define REG_FRONT_DATA		16'h0051
`define REG_FRONT_STAT		16'h0052
`define REG_FRONT_LED_0		16'h0053

// Relay command and status
`define REG_RELAY_TOGGLE	16'h0070
`define REG_RELAY_TOGGLE_1	16'h0071
`define REG_RELAY_STAT		16'h0072
`define REG_RELAY_STAT_1	16'h0073

// Page of the mux selectors, index is the output channel
`define MUXSEL_PAGE			12'h00f

`endif

// ==== verilog/mgmt_pkg.sv ====
`default_nettype none

`include "mgmt_macros.svh"

package mgmt_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Bus types

	// One byte on the register bus
	typedef logic [`MGMT_DATA_BITS-1:0] mgmt_data_t;

	// One crossbar mux selector
	typedef logic [`MUXSEL_BITS-1:0] muxsel_t;

	// Raw 16-bit sensor reading
	typedef logic [15:0] sensor_t;

	////////////////////////////////////////////////////////////////////////////
	// Register address

	// Whole word for exact register matches
	// Page and index for the selector page and multi-byte offsets
	typedef union packed {
		logic [`MGMT_ADDR_BITS-1:0] word;
		struct packed {
			// Upper 12 bits
			logic [`MGMT_ADDR_BITS-5:0] page;
			// Low nibble
			logic [3:0] index;
		} paged;
	} mgmt_addr_t;

endpackage

`default_nettype wire

// ==== verilog/mgmt_read_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mgmt_macros.svh"

module mgmt_read_mux(
	input wire							clk,
	input wire							rst_n,

	// Read side of the register bus
	input wire							rd_en,
	input wire mgmt_pkg::mgmt_addr_t	rd_addr,
	output logic						rd_valid,
	output mgmt_pkg::mgmt_data_t		rd_data,

	// Device identity, flags may come up late
	input wire [31:0]					idcode,
	input wire							idcode_valid,
	input wire [63:0]					die_serial,
	input wire							die_serial_valid,

	// Sensor readings
	input wire mgmt_pkg::sensor_t		fan0_rpm,
	input wire mgmt_pkg::sensor_t		fan1_rpm,
	input wire mgmt_pkg::sensor_t		die_temp,
	input wire mgmt_pkg::sensor_t		volt_core,
	input wire mgmt_pkg::sensor_t		volt_ram,
	input wire mgmt_pkg::sensor_t		volt_aux,

	// Peer status
	input wire							relay_busy,
	input wire							front_busy
	);

	import mgmt_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Address decode

	logic		idcode_hit;
	logic		serial_hit;
	logic		sensor_hit;
	logic		id_stall;
	logic [2:0]	serial_byte;
	logic [3:0]	sensor_off;
	sensor_t	sensor_word;
	mgmt_data_t	rd_byte;

	// Four IDCODE bytes share one aligned group
	assign idcode_hit	= (rd_addr.word >> 2) == (`REG_FPGA_IDCODE >> 2);
	assign serial_hit	= (rd_addr.word >= `REG_FPGA_SERIAL) &&
		(rd_addr.word <= `REG_FPGA_SERIAL + 16'd7);
	assign sensor_hit	= (rd_addr.word >= `REG_FAN0_RPM) &&
		(rd_addr.word <= `REG_VOLT_AUX + 16'd1);

	// Byte offsets within the multi-byte registers
	assign serial_byte	= 3'(rd_addr.word - `REG_FPGA_SERIAL);
	assign sensor_off	= 4'(rd_addr.word - `REG_FAN0_RPM);

	// Identity bytes not ready yet
	assign id_stall = (idcode_hit && !idcode_valid) || (serial_hit && !die_serial_valid);

	// Pick the 16-bit reading, two addresses per sensor
	always_comb begin
		case (sensor_off[3:1])
			3'd0:		sensor_word = fan0_rpm;
			3'd1:		sensor_word = fan1_rpm;
			3'd2:		sensor_word = die_temp;
			3'd3:		sensor_word = volt_core;
			3'd4:		sensor_word = volt_ram;
			3'd5:		sensor_word = volt_aux;
			default:	sensor_word = '0;
		endcase
	end

	// Byte mux, unmapped addresses read as zero
	always_comb begin
		rd_byte = '0;
		// Inverted offset gives big-endian order
		if (idcode_hit)
			rd_byte = idcode[{~rd_addr.paged.index[1:0], 3'b000} +: 8];
		else if (serial_hit)
			rd_byte = die_serial[{~serial_byte, 3'b000} +: 8];
		else if (sensor_hit)
			rd_byte = sensor_off[0] ? sensor_word[15:8] : sensor_word[7:0];
		else if (rd_addr.word == `REG_FRONT_STAT)
			rd_byte = {{(`MGMT_DATA_BITS-1){1'b0}}, front_busy};
		else if (rd_addr.word == `REG_RELAY_STAT_1)
			rd_byte = {{(`MGMT_DATA_BITS-1){1'b0}}, relay_busy};
	end

	////////////////////////////////////////////////////////////////////////////
	// Read sequencing

	logic reading;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reading		<= 1'b0;
			rd_valid	<= 1'b0;
			rd_data		<= '0;
		end else begin
			rd_valid <= 1'b0;

			// Hold the request until the identity flag comes up
			if (rd_en || reading) begin
				if (id_stall) begin
					reading <= 1'b1;
				end else begin
					reading		<= 1'b0;
					rd_valid	<= 1'b1;
					rd_data		<= rd_byte;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/relay_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mgmt_macros.svh"

module relay_ctrl(
	input wire							clk,
	input wire							rst_n,

	// Shared write bus
	input wire							wr_en,
	input wire mgmt_pkg::mgmt_addr_t	wr_addr,
	input wire mgmt_pkg::mgmt_data_t	wr_data,

	// Relay driver handshake
	output logic						relay_en,
	output logic						relay_dir,
	output logic [1:0]					relay_channel,
	input wire							relay_done,

	// Status
	output logic						relay_busy,
	output logic [`RELAY_CHANNELS-1:0]	relay_state
	);

	logic toggle_lo_wr;
	logic toggle_hi_wr;

	// Low byte picks the channel, high byte fires the command
	assign toggle_lo_wr = wr_en && (wr_addr.word == `REG_RELAY_TOGGLE);
	assign toggle_hi_wr = wr_en && (wr_addr.word == `REG_RELAY_TOGGLE_1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			relay_en		<= 1'b0;
			relay_dir		<= 1'b0;
			relay_channel	<= '0;
			relay_busy		<= 1'b0;
			relay_state		<= '0;
		end else begin
			relay_en <= 1'b0;

			if (toggle_lo_wr)
				relay_channel <= wr_data[1:0];

			// Bit 7 is the direction, 1 = input
			if (toggle_hi_wr) begin
				relay_dir	<= wr_data[7];
				relay_en	<= 1'b1;
			end

			// Remember what each channel was last set to
			if (relay_en)
				relay_state[relay_channel] <= relay_dir;

			// Busy goes up together with relay_en, new command wins
			if (relay_done)
				relay_busy <= 1'b0;
			if (toggle_hi_wr)
				relay_busy <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/front_panel_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mgmt_macros.svh"

module front_panel_ctrl(
	input wire							clk,
	input wire							rst_n,

	// Shared write bus
	input wire							wr_en,
	input wire mgmt_pkg::mgmt_addr_t	wr_addr,
	input wire mgmt_pkg::mgmt_data_t	wr_data,

	// Serial shifter handshake
	output logic						front_shift_en,
	output mgmt_pkg::mgmt_data_t		front_shift_data,
	input wire							front_shift_done,
	output logic						front_cs_n,
	output logic						front_busy,

	// Indicator sources
	input wire [`TRIG_CHANNELS-1:0]		trig_in_led,
	input wire [`TRIG_CHANNELS-1:0]		trig_out_led,
	input wire [`RELAY_CHANNELS-1:0]	relay_state
	);

	import mgmt_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// LED state

	logic [2*`TRIG_CHANNELS-1:0] led_state;

	always_comb begin
		led_state[`TRIG_CHANNELS-1:0] = trig_out_led;

		// Input row is wired right to left on the panel
		for (int i = 0; i < `TRIG_CHANNELS; i++)
			led_state[`TRIG_CHANNELS+i] = trig_in_led[`TRIG_CHANNELS-1-i];

		// A relay set to input never lights its output indicator
		for (int k = 0; k < `RELAY_CHANNELS; k++) begin
			if (relay_state[k])
				led_state[`TRIG_CHANNELS-`RELAY_CHANNELS+k] = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Write decode

	logic		shift_req;
	mgmt_data_t	shift_byte;

	always_comb begin
		shift_req	= 1'b0;
		shift_byte	= wr_data;
		if (wr_en) begin
			case (wr_addr.word)
				`REG_FRONT_DATA:				shift_req = 1'b1;
				`REG_FRONT_LED_0: begin
					shift_req	= 1'b1;
					shift_byte	= led_state[7:0];
				end
				`REG_FRONT_LED_0 + 16'd1: begin
					shift_req	= 1'b1;
					shift_byte	= led_state[15:8];
				end
				`REG_FRONT_LED_0 + 16'd2: begin
					shift_req	= 1'b1;
					shift_byte	= led_state[23:16];
				end
				default:						shift_req = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			front_shift_en		<= 1'b0;
			front_shift_data	<= '0;
			front_cs_n			<= 1'b1;
			front_busy			<= 1'b0;
		end else begin
			front_shift_en <= shift_req;
			if (shift_req)
				front_shift_data <= shift_byte;

			// Chip select follows CTRL bit 0 directly
			if (wr_en && (wr_addr.word == `REG_FRONT_CTRL))
				front_cs_n <= wr_data[0];

			// Busy rises with the shift strobe
			if (front_shift_done)
				front_busy <= 1'b0;
			if (shift_req)
				front_busy <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/crossbar_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mgmt_macros.svh"

module crossbar_select(
	input wire										clk,
	input wire										rst_n,

	// Shared write bus
	input wire										wr_en,
	input wire mgmt_pkg::mgmt_addr_t				wr_addr,
	input wire mgmt_pkg::mgmt_data_t				wr_data,

	// One selector per crossbar output
	output mgmt_pkg::muxsel_t [`MUX_CHANNELS-1:0]	muxsel
	);

	import mgmt_pkg::*;

	logic		sel_hit;
	muxsel_t	sel_value;

	// Selector page, indices past the last output are dropped
	assign sel_hit = wr_en && (wr_addr.paged.page == `MUXSEL_PAGE) &&
		(wr_addr.paged.index < `MUX_CHANNELS);
	assign sel_value = wr_data[`MUXSEL_BITS-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			muxsel <= '0;
		else if (sel_hit)
			muxsel[wr_addr.paged.index] <= sel_value;
	end

endmodule

`default_nettype wire

// ==== verilog/mgmt_regs_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mgmt_macros.svh"

module mgmt_regs_top(
	input wire										clk,
	input wire										rst_n,

	// Register bus
	input wire										rd_en,
	input wire mgmt_pkg::mgmt_addr_t				rd_addr,
	output logic									rd_valid,
	output mgmt_pkg::mgmt_data_t					rd_data,
	input wire										wr_en,
	input wire mgmt_pkg::mgmt_addr_t				wr_addr,
	input wire mgmt_pkg::mgmt_data_t				wr_data,

	// Identity and sensors
	input wire [31:0]								idcode,
	input wire										idcode_valid,
	input wire [63:0]								die_serial,
	input wire										die_serial_valid,
	input wire mgmt_pkg::sensor_t					fan0_rpm,
	input wire mgmt_pkg::sensor_t					fan1_rpm,
	input wire mgmt_pkg::sensor_t					die_temp,
	input wire mgmt_pkg::sensor_t					volt_core,
	input wire mgmt_pkg::sensor_t					volt_ram,
	input wire mgmt_pkg::sensor_t					volt_aux,

	// Relay driver
	output logic									relay_en,
	output logic									relay_dir,
	output logic [1:0]								relay_channel,
	input wire										relay_done,

	// Front panel
	input wire [`TRIG_CHANNELS-1:0]					trig_in_led,
	input wire [`TRIG_CHANNELS-1:0]					trig_out_led,
	output logic									front_shift_en,
	output mgmt_pkg::mgmt_data_t					front_shift_data,
	input wire										front_shift_done,
	output logic									front_cs_n,

	// Crossbar
	output mgmt_pkg::muxsel_t [`MUX_CHANNELS-1:0]	muxsel
	);

	// Peer status back into the read path
	wire						relay_busy;
	wire						front_busy;
	wire [`RELAY_CHANNELS-1:0]	relay_state;

	////////////////////////////////////////////////////////////////////////////
	// Read side

	mgmt_read_mux u_read_mux(
		.clk				(clk),
		.rst_n				(rst_n),
		.rd_en				(rd_en),
		.rd_addr			(rd_addr),
		.rd_valid			(rd_valid),
		.rd_data			(rd_data),
		.idcode				(idcode),
		.idcode_valid		(idcode_valid),
		.die_serial			(die_serial),
		.die_serial_valid	(die_serial_valid),
		.fan0_rpm			(fan0_rpm),
		.fan1_rpm			(fan1_rpm),
		.die_temp			(die_temp),
		.volt_core			(volt_core),
		.volt_ram			(volt_ram),
		.volt_aux			(volt_aux),
		.relay_busy			(relay_busy),
		.front_busy			(front_busy)
		);

	////////////////////////////////////////////////////////////////////////////
	// Write peers, all on the same bus

	relay_ctrl u_relay(
		.clk				(clk),
		.rst_n				(rst_n),
		.wr_en				(wr_en),
		.wr_addr			(wr_addr),
		.wr_data			(wr_data),
		.relay_en			(relay_en),
		.relay_dir			(relay_dir),
		.relay_channel		(relay_channel),
		.relay_done			(relay_done),
		.relay_busy			(relay_busy),
		.relay_state		(relay_state)
		);

	// Relay state masks the output LEDs
	front_panel_ctrl u_front(
		.clk				(clk),
		.rst_n				(rst_n),
		.wr_en				(wr_en),
		.wr_addr			(wr_addr),
		.wr_data			(wr_data),
		.front_shift_en		(front_shift_en),
		.front_shift_data	(front_shift_data),
		.front_shift_done	(front_shift_done),
		.front_cs_n			(front_cs_n),
		.front_busy			(front_busy),
		.trig_in_led		(trig_in_led),
		.trig_out_led		(trig_out_led),
		.relay_state		(relay_state)
		);

	crossbar_select u_xbar(
		.clk				(clk),
		.rst_n				(rst_n),
		.wr_en				(wr_en),
		.wr_addr			(wr_addr),
		.wr_data			(wr_data),
		.muxsel				(muxsel)
		);

endmodule

`default_nettype wire

// ==== test/mgmt_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module mgmt_properties(
	input wire	clk,
	input wire	rst_n,
	input wire	rd_en,
	input wire	rd_valid,
	input wire	relay_en,
	input wire	front_shift_en,
	input wire	front_cs_n,
	input wire	relay_busy,
	input wire	front_busy
	);

	////////////////////////////////////////////////////////////////////////////
	// Bus pulses

	// One read answer per request
	// A read issued on the answer cycle brings the next pulse right after it
	a_rd_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		rd_valid && !rd_en |=> !rd_valid)
		else $error("rd_valid held for more than one cycle");

	a_relay_en_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		relay_en |=> !relay_en)
		else $error("relay_en held for more than one cycle");

	a_shift_en_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		front_shift_en |=> !front_shift_en)
		else $error("front_shift_en held for more than one cycle");

	// Panel deselected and nothing busy in reset
	a_reset_idle: assert property (@(posedge clk)
		!rst_n |-> (front_cs_n && !relay_busy && !front_busy))
		else $error("front panel or relay not idle during reset");

endmodule

// Busy flags are internal wires of the top level
bind mgmt_regs_top mgmt_properties u_props(
	.clk			(clk),
	.rst_n			(rst_n),
	.rd_en			(rd_en),
	.rd_valid		(rd_valid),
	.relay_en		(relay_en),
	.front_shift_en	(front_shift_en),
	.front_cs_n		(front_cs_n),
	.relay_busy		(relay_busy),
	.front_busy		(front_busy)
	);

`default_nettype wire

// ==== test/tb_mgmt.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mgmt_macros.svh"

module tb_mgmt;

	import mgmt_pkg::*;

	// Operations in the test sequence, the watchdog allows 40 cycles for each
	localparam int NUM_OPS = 80;

	logic							clk;
	logic							rst_n;
	logic							rd_en;
	mgmt_addr_t						rd_addr;
	logic							rd_valid;
	mgmt_data_t						rd_data;
	logic							wr_en;
	mgmt_addr_t						wr_addr;
	mgmt_data_t						wr_data;
	logic [31:0]					idcode;
	logic							idcode_valid;
	logic [63:0]					die_serial;
	logic							die_serial_valid;
	sensor_t						sens [6];
	logic							relay_en;
	logic							relay_dir;
	logic [1:0]						relay_channel;
	logic							relay_done;
	logic [`TRIG_CHANNELS-1:0]		trig_in_led;
	logic [`TRIG_CHANNELS-1:0]		trig_out_led;
	logic							front_shift_en;
	mgmt_data_t						front_shift_data;
	logic							front_shift_done;
	logic							front_cs_n;
	muxsel_t [`MUX_CHANNELS-1:0]	muxsel;

	// Model state
	logic [31:0]					rng_state;
	logic							m_relay_busy;
	logic							m_front_busy;
	logic [`RELAY_CHANNELS-1:0]		m_relay_state;
	muxsel_t						exp_sel [`MUX_CHANNELS];
	// Expected read bytes in issue order
	mgmt_data_t						exp_q [$];
	string							name_q [$];
	int								fail_count;

	// Sensors in register order, fan0 first
	mgmt_regs_top DUT(
		.fan0_rpm	(sens[0]),
		.fan1_rpm	(sens[1]),
		.die_temp	(sens[2]),
		.volt_core	(sens[3]),
		.volt_ram	(sens[4]),
		.volt_aux	(sens[5]),
		.*
		);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Byte the register map gives for one read address
	function automatic mgmt_data_t ref_read(input logic [15:0] a);
		int o;
		o = int'(a);
		// Identity words, most significant byte at the lowest address
		if (o < 4)
			return idcode[8 * (3 - o) +: 8];
		if (o >= 4 && o < 12)
			return die_serial[8 * (11 - o) +: 8];
		// Sensors, low byte at the even address
		if (o >= 16 && o < 28)
			return sens[(o - 16) / 2][8 * (o % 2) +: 8];
		if (a == `REG_FRONT_STAT)
			return {7'b0, m_front_busy};
		if (a == `REG_RELAY_STAT_1)
			return {7'b0, m_relay_busy};
		return 8'h00;
	endfunction

	// Panel LED word, outputs low and inputs high in reverse
	function automatic logic [23:0] ref_led(input logic [11:0] tin, input logic [11:0] tout,
		input logic [3:0] rs);
		logic [23:0] s;
		s[11:0] = tout;
		for (int k = 0; k < 4; k++) begin
			if (rs[k])
				s[8 + k] = 1'b0;
		end
		for (int i = 0; i < 12; i++)
			s[12 + i] = tin[11 - i];
		return s;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic report_failure();
		fail_count++;
		$display("CHECKS FAILED");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic check_data(input string name, input mgmt_data_t exp, input mgmt_data_t act);
		if (act !== exp) begin
			$display("FAIL %s expected %02h actual %02h", name, exp, act);
			report_failure();
		end
	endtask

	task automatic check_sel(input string name, input muxsel_t exp, input muxsel_t act);
		if (act !== exp) begin
			$display("FAIL %s expected %0h actual %0h", name, exp, act);
			report_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAIL %s expected %0b actual %0b", name, exp, act);
			report_failure();
		end
	endtask

	// Every read-valid pulse is matched with the oldest open read
	always @(negedge clk) begin
		if (rst_n && rd_valid) begin
			if (exp_q.size() == 0) begin
				$display("rd_valid pulsed while no read was outstanding");
				report_failure();
			end else begin
				check_data(name_q.pop_front(), exp_q.pop_front(), rd_data);
			end
		end
	end

	initial begin
		repeat (NUM_OPS * 40) @(posedge clk);
		$display("Timeout, the tests did not finish within %0d cycles", NUM_OPS * 40);
		report_failure();
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus tasks

	task automatic bus_write(input logic [15:0] addr, input mgmt_data_t data);
		wr_addr.word = addr;
		wr_data = data;
		wr_en = 1'b1;
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	// Prompt reads must answer one cycle after rd_en
	task automatic bus_read(input logic [15:0] addr, input string name, input logic prompt);
		rd_addr.word = addr;
		rd_en = 1'b1;
		exp_q.push_back(ref_read(addr));
		name_q.push_back(name);
		@(negedge clk);
		rd_en = 1'b0;
		if (prompt)
			check_bit({name, " latency"}, 1'b1, rd_valid);
		while (!rd_valid)
			@(negedge clk);
	endtask

	task automatic relay_toggle(input logic [1:0] ch, input logic dir);
		bus_write(`REG_RELAY_TOGGLE, {6'b0, ch});
		bus_write(`REG_RELAY_TOGGLE_1, {dir, 7'b0});
		check_bit("relay_en", 1'b1, relay_en);
		check_bit("relay_dir", dir, relay_dir);
		check_data("relay_channel", {6'b0, ch}, {6'b0, relay_channel});
		m_relay_busy = 1'b1;
		m_relay_state[ch] = dir;
		@(negedge clk);
		check_bit("relay_en width", 1'b0, relay_en);
		bus_read(`REG_RELAY_STAT_1, "relay busy set", 1'b1);
		relay_done = 1'b1;
		@(negedge clk);
		relay_done = 1'b0;
		m_relay_busy = 1'b0;
		bus_read(`REG_RELAY_STAT_1, "relay busy clear", 1'b1);
	endtask

	// One shift to the panel, then the busy handshake
	task automatic front_shift(input logic [15:0] addr, input mgmt_data_t data,
		input mgmt_data_t exp, input string name);
		bus_write(addr, data);
		check_bit({name, " shift_en"}, 1'b1, front_shift_en);
		check_data({name, " byte"}, exp, front_shift_data);
		m_front_busy = 1'b1;
		bus_read(`REG_FRONT_STAT, {name, " busy set"}, 1'b1);
		front_shift_done = 1'b1;
		@(negedge clk);
		front_shift_done = 1'b0;
		m_front_busy = 1'b0;
		bus_read(`REG_FRONT_STAT, {name, " busy clear"}, 1'b1);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [31:0] r;
		logic [23:0] led;
		rng_state = 32'h9f39;
		fail_count = 0;
		rst_n = 1'b1;
		rd_en = 1'b0;
		rd_addr = '0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		idcode = next_rand();
		idcode_valid = 1'b1;
		die_serial = {next_rand(), next_rand()};
		die_serial_valid = 1'b1;
		for (int i = 0; i < 6; i++)
			sens[i] = 16'(next_rand());
		relay_done = 1'b0;
		trig_in_led = '0;
		trig_out_led = '0;
		front_shift_done = 1'b0;
		m_relay_busy = 1'b0;
		m_front_busy = 1'b0;
		m_relay_state = '0;
		for (int i = 0; i < `MUX_CHANNELS; i++)
			exp_sel[i] = '0;

		// Reset pulse from the first falling edge
		@(negedge clk);
		rst_n = 1'b0;
		repeat (4) @(negedge clk);
		check_bit("reset rd_valid", 1'b0, rd_valid);
		check_bit("reset relay_en", 1'b0, relay_en);
		check_bit("reset front_shift_en", 1'b0, front_shift_en);
		check_bit("reset front_cs_n", 1'b1, front_cs_n);
		for (int i = 0; i < `MUX_CHANNELS; i++)
			check_sel($sformatf("reset muxsel %0d", i), exp_sel[i], muxsel[i]);
		rst_n = 1'b1;
		@(negedge clk);

		// Identity and sensor bytes with the flags up
		for (int a = 0; a < 12; a++)
			bus_read(16'(a), $sformatf("identity byte %0d", a), 1'b1);
		for (int a = 16; a < 28; a++)
			bus_read(16'(a), $sformatf("sensor byte %02h", a), 1'b1);

		// IDCODE read held off until the flag rises
		idcode_valid = 1'b0;
		rd_addr.word = `REG_FPGA_IDCODE + 16'd2;
		rd_en = 1'b1;
		exp_q.push_back(ref_read(rd_addr.word));
		name_q.push_back("idcode after stall");
		@(negedge clk);
		rd_en = 1'b0;
		repeat (10) begin
			check_bit("idcode stall", 1'b0, rd_valid);
			@(negedge clk);
		end
		idcode_valid = 1'b1;
		while (!rd_valid)
			@(negedge clk);

		// Selectors, then the four unused indices
		for (int i = 0; i < `MUX_CHANNELS; i++) begin
			r = next_rand();
			bus_write({`MUXSEL_PAGE, 4'(i)}, r[7:0]);
			exp_sel[i] = r[3:0];
		end
		for (int i = `MUX_CHANNELS; i < 16; i++) begin
			r = next_rand();
			bus_write({`MUXSEL_PAGE, 4'(i)}, r[7:0]);
		end
		for (int i = 0; i < `MUX_CHANNELS; i++)
			check_sel($sformatf("muxsel %0d", i), exp_sel[i], muxsel[i]);
		bus_read(16'h0030, "unmapped 0x0030", 1'b1);
		bus_read({`MUXSEL_PAGE, 4'h3}, "selector page read", 1'b1);
		bus_read(`REG_RELAY_STAT, "relay stat low byte", 1'b1);

		// Channels 2 and 3 end up as inputs
		relay_toggle(2'd2, 1'b1);
		relay_toggle(2'd0, 1'b0);
		relay_toggle(2'd3, 1'b1);

		// Front panel port
		check_bit("front_cs_n idle", 1'b1, front_cs_n);
		bus_write(`REG_FRONT_CTRL, 8'h00);
		check_bit("front_cs_n select", 1'b0, front_cs_n);
		r = next_rand();
		front_shift(`REG_FRONT_DATA, r[7:0], r[7:0], "front data");
		r = next_rand();
		trig_in_led = r[11:0];
		// Relay outputs lit so the mask shows
		trig_out_led = r[23:12] | 12'hf00;
		led = ref_led(trig_in_led, trig_out_led, m_relay_state);
		for (int b = 0; b < 3; b++) begin
			r = next_rand();
			front_shift(`REG_FRONT_LED_0 + 16'(b), r[7:0], led[8 * b +: 8],
				$sformatf("led byte %0d", b));
		end
		bus_write(`REG_FRONT_CTRL, 8'h01);
		check_bit("front_cs_n release", 1'b1, front_cs_n);

		if (fail_count == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			report_failure();
		end
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+verilog
verilog/mgmt_pkg.sv
verilog/mgmt_read_mux.sv
verilog/relay_ctrl.sv
verilog/front_panel_ctrl.sv
verilog/crossbar_select.sv
verilog/mgmt_regs_top.sv
test/mgmt_properties.sv
test/tb_mgmt.sv

// ==== Makefile ====
# Verilator simulation of the management register block

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run tb_mgmt and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_mgmt -f files.f -Mdir obj_dir
	./obj_dir/Vtb_mgmt | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
